// ==== hdl/bridge_pkg.sv ====
package bridge_pkg;

   localparam int ADDR_W = 13;  // byte address space of the core memory
   localparam int DATA_W = 32;
   localparam int STRB_W = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [ADDR_W-3:0] word_addr_t;  // wishbone side drops the byte offset
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   typedef enum logic [1:0] {
      OWN_IDLE,
      OWN_AXI,
      OWN_WB
   } owner_e;

   // axi slave side, feeding the memory port
   typedef enum logic [2:0] {
      A2W_WAIT_GRANT,
      A2W_WAIT_WDATA,
      A2W_WB_WRITE,
      A2W_WB_READ,
      A2W_WRESP,
      A2W_RRESP
   } a2w_state_e;

   // core wishbone request played out on the external axi master
   typedef enum logic [2:0] {
      W2A_WAIT_GRANT,
      W2A_AW,
      W2A_AR,
      W2A_W,
      W2A_B,
      W2A_R,
      W2A_ACK
   } w2a_state_e;

endpackage

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_axi_req,
   input  logic i_wb_req,
   input  logic i_axi_done,
   input  logic i_wb_done,
   output logic o_axi_grant,
   output logic o_wb_grant
);

   bridge_pkg::owner_e owner;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         owner <= bridge_pkg::OWN_IDLE;
      end else begin
         case (owner)
            bridge_pkg::OWN_IDLE: begin
               if (i_axi_req) begin  // axi wins a tie
                  owner <= bridge_pkg::OWN_AXI;
               end else if (i_wb_req) begin
                  owner <= bridge_pkg::OWN_WB;
               end
            end
            bridge_pkg::OWN_AXI: begin
               if (i_axi_done) owner <= bridge_pkg::OWN_IDLE;
            end
            bridge_pkg::OWN_WB: begin
               if (i_wb_done) owner <= bridge_pkg::OWN_IDLE;
            end
            default: owner <= bridge_pkg::OWN_IDLE;
         endcase
      end
   end

   assign o_axi_grant = (owner == bridge_pkg::OWN_AXI);
   assign o_wb_grant  = (owner == bridge_pkg::OWN_WB);

   // a path may only finish a transaction it was granted
   a_done_from_owner: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_axi_done && !o_axi_grant) && !(i_wb_done && !o_wb_grant));

endmodule

// ==== hdl/axi_to_wb.sv ====
`timescale 1ns/100ps

module axi_to_wb (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_grant,
   // axi-lite slave
   input  bridge_pkg::addr_t      i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  bridge_pkg::addr_t      i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   input  bridge_pkg::data_t      i_wdata,
   input  bridge_pkg::strb_t      i_wstrb,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   output bridge_pkg::data_t      o_rdata,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   // wishbone master to memory
   output bridge_pkg::word_addr_t o_mwb_adr,
   output bridge_pkg::data_t      o_mwb_dat,
   output bridge_pkg::strb_t      o_mwb_sel,
   output logic                   o_mwb_we,
   output logic                   o_mwb_stb,
   input  bridge_pkg::data_t      i_mwb_rdt,
   input  logic                   i_mwb_ack,
   output logic                   o_done
);

   bridge_pkg::a2w_state_e state;
   bridge_pkg::a2w_state_e state_nxt;
   logic ld_aw;  // take write address
   logic ld_w;   // take write data and start the wishbone write
   logic ld_ar;  // take read address and start the wishbone read

   always_comb begin
      state_nxt = state;
      ld_aw     = 1'b0;
      ld_w      = 1'b0;
      ld_ar     = 1'b0;
      case (state)
         bridge_pkg::A2W_WAIT_GRANT: begin
            if (i_grant) begin
               if (i_awvalid) begin  // write before read
                  ld_aw = 1'b1;
                  if (i_wvalid) begin
                     ld_w      = 1'b1;
                     state_nxt = bridge_pkg::A2W_WB_WRITE;
                  end else begin
                     state_nxt = bridge_pkg::A2W_WAIT_WDATA;
                  end
               end else if (i_arvalid) begin
                  ld_ar     = 1'b1;
                  state_nxt = bridge_pkg::A2W_WB_READ;
               end
            end
         end
         bridge_pkg::A2W_WAIT_WDATA: begin
            if (i_wvalid) begin
               ld_w      = 1'b1;
               state_nxt = bridge_pkg::A2W_WB_WRITE;
            end
         end
         bridge_pkg::A2W_WB_WRITE: if (i_mwb_ack) state_nxt = bridge_pkg::A2W_WRESP;
         bridge_pkg::A2W_WB_READ:  if (i_mwb_ack) state_nxt = bridge_pkg::A2W_RRESP;
         bridge_pkg::A2W_WRESP:    if (i_bready) state_nxt = bridge_pkg::A2W_WAIT_GRANT;
         bridge_pkg::A2W_RRESP:    if (i_rready) state_nxt = bridge_pkg::A2W_WAIT_GRANT;
         default: state_nxt = bridge_pkg::A2W_WAIT_GRANT;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= bridge_pkg::A2W_WAIT_GRANT;
         o_awready <= 1'b0;
         o_wready  <= 1'b0;
         o_arready <= 1'b0;
         o_mwb_stb <= 1'b0;
         o_bvalid  <= 1'b0;
         o_rvalid  <= 1'b0;
      end else begin
         state     <= state_nxt;
         o_awready <= ld_aw;  // one cycle pulses
         o_wready  <= ld_w;
         o_arready <= ld_ar;
         o_mwb_stb <= (o_mwb_stb && !i_mwb_ack) || ld_w || ld_ar;
         o_bvalid  <= (state_nxt == bridge_pkg::A2W_WRESP);
         o_rvalid  <= (state_nxt == bridge_pkg::A2W_RRESP);
      end
   end

   always_ff @(posedge i_clk) begin
      if (ld_aw) o_mwb_adr <= i_awaddr[bridge_pkg::ADDR_W-1:2];
      if (ld_ar) o_mwb_adr <= i_araddr[bridge_pkg::ADDR_W-1:2];
      if (ld_w) begin
         o_mwb_dat <= i_wdata;
         o_mwb_sel <= i_wstrb;
         o_mwb_we  <= 1'b1;
      end
      if (ld_ar) begin
         o_mwb_sel <= {bridge_pkg::STRB_W{1'b1}};  // full word read
         o_mwb_we  <= 1'b0;
      end
      if (state == bridge_pkg::A2W_WB_READ && i_mwb_ack) o_rdata <= i_mwb_rdt;
   end

   // finished when the response is taken
   assign o_done = (o_bvalid && i_bready) || (o_rvalid && i_rready);

   a_stb_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      o_mwb_stb && !i_mwb_ack |=> o_mwb_stb
         && $stable({o_mwb_adr, o_mwb_dat, o_mwb_sel, o_mwb_we}));

   a_bvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_bvalid && !i_bready |=> o_bvalid);

   a_rvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

// ==== hdl/wb_to_axi.sv ====
`timescale 1ns/100ps

module wb_to_axi (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_grant,
   // wishbone slave from the core
   input  bridge_pkg::word_addr_t i_swb_adr,
   input  bridge_pkg::data_t      i_swb_dat,
   input  bridge_pkg::strb_t      i_swb_sel,
   input  logic                   i_swb_we,
   output bridge_pkg::data_t      o_swb_rdt,
   output logic                   o_swb_ack,
   // axi-lite master to the external slave
   output bridge_pkg::addr_t      o_awmaddr,
   output logic                   o_awmvalid,
   input  logic                   i_awmready,
   output bridge_pkg::addr_t      o_armaddr,
   output logic                   o_armvalid,
   input  logic                   i_armready,
   output bridge_pkg::data_t      o_wmdata,
   output bridge_pkg::strb_t      o_wmstrb,
   output logic                   o_wmvalid,
   input  logic                   i_wmready,
   input  logic                   i_bmvalid,
   output logic                   o_bmready,
   input  bridge_pkg::data_t      i_rmdata,
   input  logic                   i_rmvalid,
   output logic                   o_rmready,
   output logic                   o_done
);

   bridge_pkg::w2a_state_e state;
   bridge_pkg::w2a_state_e state_nxt;
   logic ld_req;

   always_comb begin
      state_nxt = state;
      ld_req    = 1'b0;
      case (state)
         bridge_pkg::W2A_WAIT_GRANT: begin
            if (i_grant) begin  // grant implies stb is up
               ld_req    = 1'b1;
               state_nxt = i_swb_we ? bridge_pkg::W2A_AW : bridge_pkg::W2A_AR;
            end
         end
         bridge_pkg::W2A_AW: if (i_awmready) state_nxt = bridge_pkg::W2A_W;
         bridge_pkg::W2A_W:  if (i_wmready) state_nxt = bridge_pkg::W2A_B;
         bridge_pkg::W2A_B:  if (i_bmvalid) state_nxt = bridge_pkg::W2A_ACK;
         bridge_pkg::W2A_AR: if (i_armready) state_nxt = bridge_pkg::W2A_R;
         bridge_pkg::W2A_R:  if (i_rmvalid) state_nxt = bridge_pkg::W2A_ACK;
         // response code is not checked, the core is always acked
         bridge_pkg::W2A_ACK: state_nxt = bridge_pkg::W2A_WAIT_GRANT;
         default: state_nxt = bridge_pkg::W2A_WAIT_GRANT;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state      <= bridge_pkg::W2A_WAIT_GRANT;
         o_awmvalid <= 1'b0;
         o_wmvalid  <= 1'b0;
         o_bmready  <= 1'b0;
         o_armvalid <= 1'b0;
         o_rmready  <= 1'b0;
         o_swb_ack  <= 1'b0;
      end else begin
         state      <= state_nxt;
         o_awmvalid <= (state_nxt == bridge_pkg::W2A_AW);
         o_wmvalid  <= (state_nxt == bridge_pkg::W2A_W);
         o_bmready  <= (state_nxt == bridge_pkg::W2A_B);
         o_armvalid <= (state_nxt == bridge_pkg::W2A_AR);
         o_rmready  <= (state_nxt == bridge_pkg::W2A_R);
         o_swb_ack  <= (state_nxt == bridge_pkg::W2A_ACK);
      end
   end

   always_ff @(posedge i_clk) begin
      if (ld_req) begin
         if (i_swb_we) begin
            o_awmaddr <= {i_swb_adr, 2'b00};  // word to byte address
            o_wmdata  <= i_swb_dat;
            o_wmstrb  <= i_swb_sel;
         end else begin
            o_armaddr <= {i_swb_adr, 2'b00};
         end
      end
      if (state == bridge_pkg::W2A_R && i_rmvalid) o_swb_rdt <= i_rmdata;
   end

   assign o_done = o_swb_ack;

   a_aw_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_awmvalid && !i_awmready |=> o_awmvalid && $stable(o_awmaddr));

   a_ar_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_armvalid && !i_armready |=> o_armvalid && $stable(o_armaddr));

   a_w_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wmvalid && !i_wmready |=> o_wmvalid && $stable({o_wmdata, o_wmstrb}));

endmodule

// ==== hdl/axi_wb_bridge.sv ====
`timescale 1ns/100ps

module axi_wb_bridge (
   input  logic                   i_clk,
   input  logic                   i_rst,
   // wishbone master to core memory
   output bridge_pkg::word_addr_t o_mwb_adr,
   output bridge_pkg::data_t      o_mwb_dat,
   output bridge_pkg::strb_t      o_mwb_sel,
   output logic                   o_mwb_we,
   output logic                   o_mwb_stb,
   input  bridge_pkg::data_t      i_mwb_rdt,
   input  logic                   i_mwb_ack,
   // wishbone slave from the core
   input  bridge_pkg::word_addr_t i_swb_adr,
   input  bridge_pkg::data_t      i_swb_dat,
   input  bridge_pkg::strb_t      i_swb_sel,
   input  logic                   i_swb_we,
   input  logic                   i_swb_stb,
   output bridge_pkg::data_t      o_swb_rdt,
   output logic                   o_swb_ack,
   // axi-lite slave from an external master
   input  bridge_pkg::addr_t      i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  bridge_pkg::addr_t      i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   input  bridge_pkg::data_t      i_wdata,
   input  bridge_pkg::strb_t      i_wstrb,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   output bridge_pkg::data_t      o_rdata,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   // axi-lite master to an external slave
   output bridge_pkg::addr_t      o_awmaddr,
   output logic                   o_awmvalid,
   input  logic                   i_awmready,
   output bridge_pkg::addr_t      o_armaddr,
   output logic                   o_armvalid,
   input  logic                   i_armready,
   output bridge_pkg::data_t      o_wmdata,
   output bridge_pkg::strb_t      o_wmstrb,
   output logic                   o_wmvalid,
   input  logic                   i_wmready,
   input  logic                   i_bmvalid,
   output logic                   o_bmready,
   input  bridge_pkg::data_t      i_rmdata,
   input  logic                   i_rmvalid,
   output logic                   o_rmready
);

   logic axi_grant;
   logic wb_grant;
   logic axi_done;
   logic wb_done;

   bus_arbiter i_bus_arbiter (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_axi_req   (i_awvalid | i_arvalid),  // kind of request decoded in the path
      .i_wb_req    (i_swb_stb),
      .i_axi_done  (axi_done),
      .i_wb_done   (wb_done),
      .o_axi_grant (axi_grant),
      .o_wb_grant  (wb_grant)
   );

   axi_to_wb i_axi_to_wb (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_grant   (axi_grant),
      .i_awaddr  (i_awaddr),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_araddr  (i_araddr),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .o_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .o_rdata   (o_rdata),
      .o_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .o_mwb_adr (o_mwb_adr),
      .o_mwb_dat (o_mwb_dat),
      .o_mwb_sel (o_mwb_sel),
      .o_mwb_we  (o_mwb_we),
      .o_mwb_stb (o_mwb_stb),
      .i_mwb_rdt (i_mwb_rdt),
      .i_mwb_ack (i_mwb_ack),
      .o_done    (axi_done)
   );

   wb_to_axi i_wb_to_axi (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_grant    (wb_grant),
      .i_swb_adr  (i_swb_adr),
      .i_swb_dat  (i_swb_dat),
      .i_swb_sel  (i_swb_sel),
      .i_swb_we   (i_swb_we),
      .o_swb_rdt  (o_swb_rdt),
      .o_swb_ack  (o_swb_ack),
      .o_awmaddr  (o_awmaddr),
      .o_awmvalid (o_awmvalid),
      .i_awmready (i_awmready),
      .o_armaddr  (o_armaddr),
      .o_armvalid (o_armvalid),
      .i_armready (i_armready),
      .o_wmdata   (o_wmdata),
      .o_wmstrb   (o_wmstrb),
      .o_wmvalid  (o_wmvalid),
      .i_wmready  (i_wmready),
      .i_bmvalid  (i_bmvalid),
      .o_bmready  (o_bmready),
      .i_rmdata   (i_rmdata),
      .i_rmvalid  (i_rmvalid),
      .o_rmready  (o_rmready),
      .o_done     (wb_done)
   );

endmodule

// ==== testbench/tb_axi_wb_bridge.sv ====
`timescale 1ns/100ps

module tb_axi_wb_bridge;

   localparam int TIMEOUT_CYCLES = 8000;  // about 160 transactions of 50 cycles at most
   localparam int NUM_WORDS = 2 ** (bridge_pkg::ADDR_W - 2);

   logic i_clk = 1'b0;
   logic i_rst;
   bridge_pkg::word_addr_t o_mwb_adr, i_swb_adr;
   bridge_pkg::data_t o_mwb_dat, i_mwb_rdt, i_swb_dat, o_swb_rdt, i_wdata, o_rdata;
   bridge_pkg::data_t o_wmdata, i_rmdata;
   bridge_pkg::strb_t o_mwb_sel, i_swb_sel, i_wstrb, o_wmstrb;
   bridge_pkg::addr_t i_awaddr, i_araddr, o_awmaddr, o_armaddr;
   logic o_mwb_we, o_mwb_stb, i_mwb_ack, i_swb_we, i_swb_stb, o_swb_ack;
   logic i_awvalid, o_awready, i_arvalid, o_arready, i_wvalid, o_wready;
   logic o_bvalid, i_bready, o_rvalid, i_rready;
   logic o_awmvalid, i_awmready, o_armvalid, i_armready, o_wmvalid, i_wmready;
   logic i_bmvalid, o_bmready, i_rmvalid, o_rmready;

   int errors = 0;
   int tests_ok = 0;
   int tests_bad = 0;
   int cycles = 0;
   bridge_pkg::data_t mem_model [NUM_WORDS];  // memory behind the wishbone port
   bridge_pkg::data_t exp_mem [NUM_WORDS];    // expected contents
   bridge_pkg::word_addr_t exp_mwb_adr;
   logic last_mwb_we;
   bridge_pkg::addr_t last_awmaddr, last_armaddr;
   bridge_pkg::data_t last_wmdata, last_rmdata;
   bridge_pkg::strb_t last_wmstrb;
   time t_axi_end, t_wb_end;

   axi_wb_bridge i_axi_wb_bridge (.*);

   always #5 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic step();
      @(posedge i_clk);
      #1;  // inputs change once outputs have settled
   endtask

   // expected word after a write merges the new bytes by strobe
   function automatic bridge_pkg::data_t merge_word(bridge_pkg::data_t old,
         bridge_pkg::data_t wr, bridge_pkg::strb_t strb);
      bridge_pkg::data_t res;
      res = old;
      for (int b = 0; b < bridge_pkg::STRB_W; b++) begin
         if (strb[b]) res[b*8 +: 8] = wr[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic end_test(string name, int err_start);
      if (errors == err_start) begin
         tests_ok++;
         $display("test %s ok", name);
      end else begin
         tests_bad++;
         $display("test %s failed with %0d errors", name, errors - err_start);
      end
   endtask

   task automatic axi_write(bridge_pkg::addr_t addr, bridge_pkg::data_t data,
         bridge_pkg::strb_t strb);
      logic hs;
      logic seen;
      i_awaddr    = addr;
      i_wdata     = data;
      i_wstrb     = strb;
      i_awvalid   = 1'b1;
      i_wvalid    = 1'b1;
      exp_mwb_adr = addr / 4;
      do step(); while (!o_awready);
      check("wready_with_awready", 1, o_wready);
      step();
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      hs = 1'b0;
      while (!hs) begin
         seen = o_bvalid;
         if (seen) begin
            i_bready = $urandom % 2;  // random back-pressure
            hs = i_bready;
         end
         step();
         if (seen && !hs) check("bvalid_stall", 1, o_bvalid);
      end
      i_bready  = 1'b0;
      t_axi_end = $time;
   endtask

   task automatic axi_read(bridge_pkg::addr_t addr, output bridge_pkg::data_t rd);
      logic hs;
      logic seen;
      bridge_pkg::data_t held;
      i_araddr    = addr;
      i_arvalid   = 1'b1;
      exp_mwb_adr = addr / 4;
      do step(); while (!o_arready);
      step();
      i_arvalid = 1'b0;
      hs = 1'b0;
      while (!hs) begin
         seen = o_rvalid;
         held = o_rdata;
         if (seen) begin
            i_rready = $urandom % 2;
            hs = i_rready;
         end
         step();
         if (seen && !hs) begin
            check("rvalid_stall", 1, o_rvalid);
            check("rdata_stall", held, o_rdata);
         end
      end
      rd = held;
      i_rready  = 1'b0;
      t_axi_end = $time;
   endtask

   task automatic wb_access(logic we, bridge_pkg::word_addr_t adr, bridge_pkg::data_t dat,
         bridge_pkg::strb_t sel, output bridge_pkg::data_t rd);
      i_swb_adr = adr;
      i_swb_dat = dat;
      i_swb_sel = sel;
      i_swb_we  = we;
      i_swb_stb = 1'b1;
      do step(); while (!o_swb_ack);
      rd = o_swb_rdt;
      i_swb_stb = 1'b0;  // core lets go once acked
      t_wb_end  = $time;
   endtask

   // wishbone memory that acks 1 to 3 cycles after stb
   initial begin
      int n;
      forever begin
         step();
         if (o_mwb_stb) begin
            check("mwb_adr", exp_mwb_adr, o_mwb_adr);
            last_mwb_we = o_mwb_we;
            n = $urandom % 3;
            repeat (n) begin
               step();
               check("mwb_stb_hold", 1, o_mwb_stb);
            end
            if (o_mwb_we) mem_model[o_mwb_adr] = merge_word(mem_model[o_mwb_adr],
               o_mwb_dat, o_mwb_sel);
            else i_mwb_rdt = mem_model[o_mwb_adr];
            i_mwb_ack = 1'b1;
            step();
            i_mwb_ack = 1'b0;
         end
      end
   end

   // external axi slave with 0 to 4 cycles of ready delay per phase
   initial begin
      int n;
      forever begin
         step();
         if (o_awmvalid) begin
            last_awmaddr = o_awmaddr;
            n = $urandom % 5;
            repeat (n) begin
               step();
               check("awmvalid_stall", 1, o_awmvalid);
               check("awmaddr_stall", last_awmaddr, o_awmaddr);
            end
            i_awmready = 1'b1;
            step();
            i_awmready  = 1'b0;
            last_wmdata = o_wmdata;
            last_wmstrb = o_wmstrb;
            n = $urandom % 5;
            repeat (n) begin
               step();
               check("wmvalid_stall", 1, o_wmvalid);
               check("wmdata_stall", last_wmdata, o_wmdata);
               check("wmstrb_stall", last_wmstrb, o_wmstrb);
            end
            i_wmready = 1'b1;
            step();
            i_wmready = 1'b0;
            repeat ($urandom % 5) step();
            i_bmvalid = 1'b1;
            while (!o_bmready) step();  // response held until the bridge takes it
            step();
            i_bmvalid = 1'b0;
         end else if (o_armvalid) begin
            last_armaddr = o_armaddr;
            n = $urandom % 5;
            repeat (n) begin
               step();
               check("armvalid_stall", 1, o_armvalid);
               check("armaddr_stall", last_armaddr, o_armaddr);
            end
            i_armready = 1'b1;
            step();
            i_armready = 1'b0;
            repeat ($urandom % 5) step();
            last_rmdata = $urandom;
            i_rmdata    = last_rmdata;
            i_rmvalid   = 1'b1;
            while (!o_rmready) step();
            step();
            i_rmvalid = 1'b0;
         end
      end
   end

   initial begin
      bridge_pkg::addr_t addrs [20];
      bridge_pkg::addr_t a;
      bridge_pkg::data_t d, rd;
      bridge_pkg::strb_t s;
      bridge_pkg::word_addr_t wa;
      int err0;
      logic we;
      i_rst = 1'b1;
      {i_awaddr, i_awvalid, i_araddr, i_arvalid, i_wdata, i_wstrb, i_wvalid} = '0;
      {i_bready, i_rready, i_mwb_rdt, i_mwb_ack} = '0;
      {i_swb_adr, i_swb_dat, i_swb_sel, i_swb_we, i_swb_stb} = '0;
      {i_awmready, i_armready, i_wmready, i_bmvalid, i_rmdata, i_rmvalid} = '0;
      void'($urandom(32'heb51a506));
      for (int i = 0; i < NUM_WORDS; i++) begin
         mem_model[i] = '0;
         exp_mem[i]   = '0;
      end
      repeat (8) @(posedge i_clk);
      #1 i_rst = 1'b0;

      err0 = errors;
      step();
      check("reset_idle", 0, {o_awready, o_arready, o_wready, o_bvalid, o_rvalid, o_mwb_stb,
         o_swb_ack, o_awmvalid, o_armvalid, o_wmvalid, o_bmready, o_rmready});
      end_test("reset_idle", err0);

      err0 = errors;
      for (int i = 0; i < 20; i++) begin
         addrs[i] = $urandom;
         d = $urandom;
         s = $urandom;
         exp_mem[addrs[i][12:2]] = merge_word(exp_mem[addrs[i][12:2]], d, s);
         axi_write(addrs[i], d, s);
      end
      for (int i = 0; i < 20; i++) begin
         axi_read(addrs[i], rd);
         check("axi_read", exp_mem[addrs[i][12:2]], rd);
      end
      end_test("axi_to_memory", err0);

      err0 = errors;
      for (int i = 0; i < 20; i++) begin
         we = $urandom % 2;
         wa = $urandom;
         d  = $urandom;
         s  = $urandom;
         wb_access(we, wa, d, s, rd);
         if (we) begin
            check("awmaddr", wa * 4, last_awmaddr);
            check("wmdata", d, last_wmdata);
            check("wmstrb", s, last_wmstrb);
         end else begin
            check("armaddr", wa * 4, last_armaddr);
            check("swb_rdt", last_rmdata, rd);
         end
      end
      end_test("core_to_axi", err0);

      err0 = errors;
      a = $urandom;
      d = $urandom;
      s = $urandom;
      exp_mem[a[12:2]] = merge_word(exp_mem[a[12:2]], d, s);
      i_araddr  = a;
      i_arvalid = 1'b1;  // raised with awvalid in the same cycle
      axi_write(a, d, s);
      check("write_before_read", 1, last_mwb_we);
      axi_read(a, rd);
      check("axi_read_after_tie", exp_mem[a[12:2]], rd);
      a  = $urandom;
      wa = $urandom;
      exp_mem[a[12:2]] = merge_word(exp_mem[a[12:2]], d, s);
      fork
         axi_write(a, d, s);
         wb_access(1'b1, wa, d, s, rd);
      join
      check("axi_before_core", 1, t_axi_end < t_wb_end);
      check("awmaddr_after_tie", wa * 4, last_awmaddr);
      axi_read(a, rd);
      check("axi_read_after_core_tie", exp_mem[a[12:2]], rd);
      end_test("priority", err0);

      $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== axi_wb_bridge.f ====
hdl/bridge_pkg.sv
hdl/bus_arbiter.sv
hdl/axi_to_wb.sv
hdl/wb_to_axi.sv
hdl/axi_wb_bridge.sv
testbench/tb_axi_wb_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axi_wb_bridge.f \
   --top-module tb_axi_wb_bridge -o sim_tb_axi_wb_bridge \
   && ./obj_dir/sim_tb_axi_wb_bridge | tee /dev/stderr | grep -q "Verification passed" \
   && echo "simulation PASS" \
   || { echo "simulation FAIL"; exit 1; }
